// File: verilog/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN 32
`define EX_REG_ADDR_W 5
`define EX_OP_W 6
`define EX_DIV_STEPS 32

// Single-cycle operations
`define EX_OP_ADD 6'd0
`define EX_OP_SUB 6'd1
`define EX_OP_AND 6'd2
`define EX_OP_OR 6'd3
`define EX_OP_XOR 6'd4
`define EX_OP_NOR 6'd5
`define EX_OP_SLL 6'd6
`define EX_OP_SRL 6'd7
`define EX_OP_SRA 6'd8
`define EX_OP_SLT 6'd9
`define EX_OP_SLTU 6'd10
`define EX_OP_LUI 6'd11
`define EX_OP_PCADD 6'd12

// Multi-cycle operations
`define EX_OP_MUL 6'd16
`define EX_OP_MULH 6'd17
`define EX_OP_MULHU 6'd18
`define EX_OP_DIV 6'd19
`define EX_OP_DIVU 6'd20
`define EX_OP_MOD 6'd21
`define EX_OP_MODU 6'd22

// Branches and jump
`define EX_OP_BEQ 6'd32
`define EX_OP_BNE 6'd33
`define EX_OP_BLT 6'd34
`define EX_OP_BGE 6'd35
`define EX_OP_BLTU 6'd36
`define EX_OP_BGEU 6'd37
`define EX_OP_JIRL 6'd38

// Loads and stores
`define EX_OP_LDW 6'd48
`define EX_OP_LDH 6'd49
`define EX_OP_LDB 6'd50
`define EX_OP_STW 6'd51
`define EX_OP_STH 6'd52
`define EX_OP_STB 6'd53

`endif

// File: verilog/ex_pkg.sv
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EX_OP_W-1:0] aluop_t;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] mem_size_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    // Launch state of the multi-cycle ops
    typedef enum logic [1:0] {
        MD_IDLE,
        MD_WAIT,
        MD_HOLD
    } md_state_t;

endpackage

`default_nettype wire

// File: verilog/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_alu (
    input  wire ex_pkg::aluop_t op_i,
    input  wire ex_pkg::word_t  pc_i,
    input  wire ex_pkg::word_t  op1_i,
    input  wire ex_pkg::word_t  op2_i,
    input  wire ex_pkg::word_t  imm_i,
    output ex_pkg::word_t       alu_result_o,
    output ex_pkg::word_t       branch_target_o,
    output logic                branch_taken_o
);
    import ex_pkg::*;

    word_t sum;
    word_t diff;
    logic  lt_s;
    logic  lt_u;

    assign sum  = op1_i + op2_i;
    assign diff = op1_i - op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (op_i)
            `EX_OP_ADD:   alu_result_o = sum;
            `EX_OP_SUB:   alu_result_o = diff;
            `EX_OP_AND:   alu_result_o = op1_i & op2_i;
            `EX_OP_OR:    alu_result_o = op1_i | op2_i;
            `EX_OP_XOR:   alu_result_o = op1_i ^ op2_i;
            `EX_OP_NOR:   alu_result_o = ~(op1_i | op2_i);
            `EX_OP_SLL:   alu_result_o = op1_i << op2_i[4:0];
            `EX_OP_SRL:   alu_result_o = op1_i >> op2_i[4:0];
            `EX_OP_SRA:   alu_result_o = word_t'($signed(op1_i) >>> op2_i[4:0]);
            `EX_OP_SLT:   alu_result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
            `EX_OP_SLTU:  alu_result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
            `EX_OP_LUI:   alu_result_o = op2_i;
            `EX_OP_PCADD: alu_result_o = pc_i + op2_i;
            // Link value
            `EX_OP_JIRL:  alu_result_o = pc_i + word_t'(4);
            default:      alu_result_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            `EX_OP_BEQ:  branch_taken_o = (diff == '0);
            `EX_OP_BNE:  branch_taken_o = (diff != '0);
            `EX_OP_BLT:  branch_taken_o = lt_s;
            `EX_OP_BGE:  branch_taken_o = !lt_s;
            `EX_OP_BLTU: branch_taken_o = lt_u;
            `EX_OP_BGEU: branch_taken_o = !lt_u;
            `EX_OP_JIRL: branch_taken_o = 1'b1;
            default:     branch_taken_o = 1'b0;
        endcase
    end

    // Register-indirect for JIRL, PC-relative otherwise
    assign branch_target_o = (op_i == `EX_OP_JIRL) ? op1_i + imm_i : pc_i + imm_i;

endmodule

`default_nettype wire

// File: verilog/ex_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_mul_unit (
    input  wire                clk,
    input  wire                rst,
    input  wire                start_i,
    input  wire                high_i,
    input  wire                signed_i,
    input  wire ex_pkg::word_t a_i,
    input  wire ex_pkg::word_t b_i,
    output logic               done_o,
    output ex_pkg::word_t      result_o
);
    import ex_pkg::*;

    logic [`EX_XLEN:0] a_q;
    logic [`EX_XLEN:0] b_q;
    logic              high_q;
    logic              v1_q;
    logic [2*`EX_XLEN+1:0] prod;

    // Extra top bit lets one signed multiplier cover both signednesses
    assign prod = $signed(a_q) * $signed(b_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q   <= 1'b0;
            done_o <= 1'b0;
        end else begin
            v1_q   <= start_i;
            done_o <= v1_q;
        end
    end

    always_ff @(posedge clk) begin
        a_q      <= {signed_i & a_i[`EX_XLEN-1], a_i};
        b_q      <= {signed_i & b_i[`EX_XLEN-1], b_i};
        high_q   <= high_i;
        result_o <= high_q ? prod[2*`EX_XLEN-1:`EX_XLEN] : word_t'(prod[`EX_XLEN-1:0]);
    end

endmodule

`default_nettype wire

// File: verilog/ex_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_div_unit (
    input  wire                clk,
    input  wire                rst,
    input  wire                start_i,
    input  wire                abort_i,
    input  wire                signed_i,
    input  wire                rem_i,
    input  wire ex_pkg::word_t dividend_i,
    input  wire ex_pkg::word_t divisor_i,
    output logic               done_o,
    output ex_pkg::word_t      result_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`EX_DIV_STEPS);

    div_state_t        state_q;
    logic [CNT_W-1:0]  cnt_q;
    word_t             quo_q;
    word_t             rem_q;
    word_t             dvs_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              rem_sel_q;
    word_t             divisor_nz;
    word_t             dividend_abs;
    word_t             divisor_abs;
    logic [`EX_XLEN:0] rem_shift;
    logic [`EX_XLEN:0] trial;

    // Divide by zero runs as divide by one
    assign divisor_nz   = (divisor_i == '0) ? word_t'(1) : divisor_i;
    assign dividend_abs = (signed_i & dividend_i[`EX_XLEN-1]) ? -dividend_i : dividend_i;
    assign divisor_abs  = (signed_i & divisor_nz[`EX_XLEN-1]) ? -divisor_nz : divisor_nz;

    assign rem_shift = {rem_q, quo_q[`EX_XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else if (abort_i) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        cnt_q   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`EX_DIV_STEPS - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    ////////////////////
    // Restoring shift-subtract datapath
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            quo_q     <= dividend_abs;
            rem_q     <= '0;
            dvs_q     <= divisor_abs;
            q_neg_q   <= signed_i & (dividend_i[`EX_XLEN-1] ^ divisor_nz[`EX_XLEN-1]);
            r_neg_q   <= signed_i & dividend_i[`EX_XLEN-1];
            rem_sel_q <= rem_i;
        end else if (state_q == DIV_RUN) begin
            if (!trial[`EX_XLEN]) begin
                rem_q <= trial[`EX_XLEN-1:0];
                quo_q <= {quo_q[`EX_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[`EX_XLEN-1:0];
                quo_q <= {quo_q[`EX_XLEN-2:0], 1'b0};
            end
        end
    end

    assign done_o   = (state_q == DIV_DONE);
    // Remainder follows the dividend's sign
    assign result_o = rem_sel_q ? (r_neg_q ? -rem_q : rem_q) : (q_neg_q ? -quo_q : quo_q);

endmodule

`default_nettype wire

// File: verilog/ex_mem_addr.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_mem_addr (
    input  wire ex_pkg::aluop_t op_i,
    input  wire ex_pkg::word_t  base_i,
    input  wire ex_pkg::word_t  imm_i,
    output ex_pkg::word_t       addr_o,
    output ex_pkg::mem_size_t   size_o,
    output logic                load_o,
    output logic                store_o,
    output logic                excp_ale_o
);

    logic misaligned;

    assign addr_o  = base_i + imm_i;
    assign load_o  = (op_i == `EX_OP_LDW) | (op_i == `EX_OP_LDH) | (op_i == `EX_OP_LDB);
    assign store_o = (op_i == `EX_OP_STW) | (op_i == `EX_OP_STH) | (op_i == `EX_OP_STB);

    always_comb begin
        case (op_i)
            `EX_OP_LDB, `EX_OP_STB: size_o = 2'd0;
            `EX_OP_LDH, `EX_OP_STH: size_o = 2'd1;
            default:                size_o = 2'd2;
        endcase
    end

    // Byte accesses never fault
    assign misaligned = (size_o == 2'd1) ? addr_o[0] :
                        (size_o == 2'd2) ? |addr_o[1:0] : 1'b0;
    assign excp_ale_o = (load_o | store_o) & misaligned;

endmodule

`default_nettype wire

// File: verilog/ex_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    flush_i,
    input  wire                    advance_i,
    input  wire                    in_valid_i,
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire                    wreg_i,
    input  wire ex_pkg::reg_addr_t waddr_i,
    input  wire                    predicted_taken_i,
    input  wire ex_pkg::word_t     alu_result_i,
    input  wire                    branch_taken_i,
    input  wire ex_pkg::word_t     branch_target_i,
    input  wire                    mul_done_i,
    input  wire ex_pkg::word_t     mul_result_i,
    input  wire                    div_done_i,
    input  wire ex_pkg::word_t     div_result_i,
    input  wire ex_pkg::word_t     mem_addr_i,
    input  wire ex_pkg::mem_size_t mem_size_i,
    input  wire                    mem_load_i,
    input  wire                    mem_store_i,
    input  wire                    mem_excp_ale_i,
    output logic                   advance_ready_o,
    output logic                   mul_start_o,
    output logic                   mul_high_o,
    output logic                   mul_signed_o,
    output logic                   div_start_o,
    output logic                   div_abort_o,
    output logic                   div_signed_o,
    output logic                   div_rem_o,
    output logic                   out_valid_o,
    output logic                   out_wreg_o,
    output ex_pkg::reg_addr_t      out_waddr_o,
    output ex_pkg::word_t          out_wdata_o,
    output ex_pkg::word_t          out_mem_addr_o,
    output ex_pkg::mem_size_t      out_mem_size_o,
    output logic                   out_load_o,
    output logic                   out_store_o,
    output logic                   out_excp_ale_o,
    output logic                   fwd_valid_o,
    output logic                   fwd_data_ready_o,
    output ex_pkg::reg_addr_t      fwd_waddr_o,
    output ex_pkg::word_t          fwd_wdata_o,
    output logic                   redirect_o,
    output ex_pkg::word_t          redirect_target_o
);
    import ex_pkg::*;

    md_state_t state_q;
    word_t     md_result_q;
    word_t     wdata;
    logic      is_mul;
    logic      is_div;
    logic      md_valid;
    logic      md_done;
    logic      accept;

    assign is_mul = (aluop_i == `EX_OP_MUL) | (aluop_i == `EX_OP_MULH) |
                    (aluop_i == `EX_OP_MULHU);
    assign is_div = (aluop_i == `EX_OP_DIV) | (aluop_i == `EX_OP_DIVU) |
                    (aluop_i == `EX_OP_MOD) | (aluop_i == `EX_OP_MODU);
    assign md_valid = in_valid_i & (is_mul | is_div);

    assign mul_high_o   = (aluop_i != `EX_OP_MUL);
    assign mul_signed_o = (aluop_i != `EX_OP_MULHU);
    assign div_signed_o = (aluop_i == `EX_OP_DIV) | (aluop_i == `EX_OP_MOD);
    assign div_rem_o    = (aluop_i == `EX_OP_MOD) | (aluop_i == `EX_OP_MODU);
    assign div_abort_o  = flush_i;

    ////////////////////
    // Mul/div launch
    // A done in the start cycle belongs to a flushed multiply
    assign md_done = (mul_done_i | div_done_i) & !mul_start_o & !div_start_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= MD_IDLE;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
        end else begin
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            if (flush_i) begin
                state_q <= MD_IDLE;
            end else begin
                case (state_q)
                    MD_IDLE: begin
                        if (md_valid) begin
                            state_q     <= MD_WAIT;
                            mul_start_o <= is_mul;
                            div_start_o <= is_div;
                        end
                    end
                    MD_WAIT: if (md_done) state_q <= MD_HOLD;
                    MD_HOLD: if (advance_i) state_q <= MD_IDLE;
                    default: state_q <= MD_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MD_WAIT && md_done) begin
            md_result_q <= mul_done_i ? mul_result_i : div_result_i;
        end
    end

    assign advance_ready_o = !md_valid | (state_q == MD_HOLD);
    assign accept          = advance_i & advance_ready_o;

    ////////////////////
    // Forwarding and redirect
    assign wdata            = (is_mul | is_div) ? md_result_q : alu_result_i;
    assign fwd_valid_o      = in_valid_i & wreg_i;
    assign fwd_data_ready_o = !mem_load_i & (!(is_mul | is_div) | (state_q == MD_HOLD));
    assign fwd_waddr_o      = waddr_i;
    assign fwd_wdata_o      = wdata;

    assign redirect_o = accept & in_valid_i & branch_taken_i &
                        (!predicted_taken_i | (aluop_i == `EX_OP_JIRL));
    assign redirect_target_o = branch_target_i;

    ////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            out_valid_o    <= 1'b0;
            out_wreg_o     <= 1'b0;
            out_load_o     <= 1'b0;
            out_store_o    <= 1'b0;
            out_excp_ale_o <= 1'b0;
        end else if (accept) begin
            out_valid_o    <= in_valid_i;
            out_wreg_o     <= in_valid_i & wreg_i;
            out_load_o     <= in_valid_i & mem_load_i;
            out_store_o    <= in_valid_i & mem_store_i;
            out_excp_ale_o <= in_valid_i & mem_excp_ale_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_waddr_o    <= waddr_i;
            out_wdata_o    <= wdata;
            out_mem_addr_o <= mem_addr_i;
            out_mem_size_o <= mem_size_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid_i,
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire ex_pkg::word_t     pc_i,
    input  wire ex_pkg::word_t     op1_i,
    input  wire ex_pkg::word_t     op2_i,
    input  wire ex_pkg::word_t     imm_i,
    input  wire ex_pkg::reg_addr_t waddr_i,
    input  wire                    wreg_i,
    input  wire                    predicted_taken_i,
    input  wire                    advance_i,
    input  wire                    flush_i,
    output logic                   advance_ready_o,
    output logic                   out_valid_o,
    output logic                   out_wreg_o,
    output ex_pkg::reg_addr_t      out_waddr_o,
    output ex_pkg::word_t          out_wdata_o,
    output ex_pkg::word_t          out_mem_addr_o,
    output ex_pkg::mem_size_t      out_mem_size_o,
    output logic                   out_load_o,
    output logic                   out_store_o,
    output logic                   out_excp_ale_o,
    output logic                   fwd_valid_o,
    output logic                   fwd_data_ready_o,
    output ex_pkg::reg_addr_t      fwd_waddr_o,
    output ex_pkg::word_t          fwd_wdata_o,
    output logic                   redirect_o,
    output ex_pkg::word_t          redirect_target_o
);
    import ex_pkg::*;

    word_t     alu_result;
    word_t     branch_target;
    word_t     mul_result;
    word_t     div_result;
    word_t     mem_addr;
    mem_size_t mem_size;
    logic      branch_taken;
    logic      mul_start;
    logic      mul_high;
    logic      mul_signed;
    logic      mul_done;
    logic      div_start;
    logic      div_abort;
    logic      div_signed;
    logic      div_rem;
    logic      div_done;
    logic      mem_load;
    logic      mem_store;
    logic      mem_excp_ale;

    ex_ctrl ctrl0 (
        .clk(clk), .rst(rst), .flush_i(flush_i), .advance_i(advance_i),
        .in_valid_i(in_valid_i), .aluop_i(aluop_i), .wreg_i(wreg_i), .waddr_i(waddr_i),
        .predicted_taken_i(predicted_taken_i), .alu_result_i(alu_result),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .mul_done_i(mul_done), .mul_result_i(mul_result),
        .div_done_i(div_done), .div_result_i(div_result),
        .mem_addr_i(mem_addr), .mem_size_i(mem_size), .mem_load_i(mem_load),
        .mem_store_i(mem_store), .mem_excp_ale_i(mem_excp_ale),
        .advance_ready_o(advance_ready_o),
        .mul_start_o(mul_start), .mul_high_o(mul_high), .mul_signed_o(mul_signed),
        .div_start_o(div_start), .div_abort_o(div_abort),
        .div_signed_o(div_signed), .div_rem_o(div_rem),
        .out_valid_o(out_valid_o), .out_wreg_o(out_wreg_o),
        .out_waddr_o(out_waddr_o), .out_wdata_o(out_wdata_o),
        .out_mem_addr_o(out_mem_addr_o), .out_mem_size_o(out_mem_size_o),
        .out_load_o(out_load_o), .out_store_o(out_store_o),
        .out_excp_ale_o(out_excp_ale_o),
        .fwd_valid_o(fwd_valid_o), .fwd_data_ready_o(fwd_data_ready_o),
        .fwd_waddr_o(fwd_waddr_o), .fwd_wdata_o(fwd_wdata_o),
        .redirect_o(redirect_o), .redirect_target_o(redirect_target_o)
    );

    ex_alu alu0 (
        .op_i(aluop_i), .pc_i(pc_i), .op1_i(op1_i), .op2_i(op2_i), .imm_i(imm_i),
        .alu_result_o(alu_result), .branch_target_o(branch_target),
        .branch_taken_o(branch_taken)
    );

    ex_mul_unit mul0 (
        .clk(clk), .rst(rst), .start_i(mul_start), .high_i(mul_high),
        .signed_i(mul_signed), .a_i(op1_i), .b_i(op2_i),
        .done_o(mul_done), .result_o(mul_result)
    );

    ex_div_unit div0 (
        .clk(clk), .rst(rst), .start_i(div_start), .abort_i(div_abort),
        .signed_i(div_signed), .rem_i(div_rem), .dividend_i(op1_i), .divisor_i(op2_i),
        .done_o(div_done), .result_o(div_result)
    );

    ex_mem_addr addr0 (
        .op_i(aluop_i), .base_i(op1_i), .imm_i(imm_i),
        .addr_o(mem_addr), .size_o(mem_size), .load_o(mem_load),
        .store_o(mem_store), .excp_ale_o(mem_excp_ale)
    );

endmodule

`default_nettype wire

// File: tests/ex_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage_assert (
    input wire                 clk,
    input wire                 rst,
    input wire                 flush_i,
    input wire                 advance_i,
    input wire                 in_valid_i,
    input wire ex_pkg::aluop_t aluop_i,
    input wire                 advance_ready_i,
    input wire                 out_valid_i,
    input wire                 redirect_i,
    input wire                 mul_start_i,
    input wire                 mul_done_i
);
    import ex_pkg::*;

    logic md_op;
    int   fail_count;

    initial fail_count = 0;

    assign md_op = in_valid_i && (aluop_i >= `EX_OP_MUL) && (aluop_i <= `EX_OP_MODU);

    flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !out_valid_i)
        else begin
            $error("out_valid_o still high the cycle after a flush");
            fail_count++;
        end

    redirect_with_advance: assert property (@(posedge clk) disable iff (rst)
        redirect_i |-> advance_i)
        else begin
            $error("redirect_o raised without advance_i");
            fail_count++;
        end

    // Only a pending multiply or divide may stall
    stall_only_md: assert property (@(posedge clk) disable iff (rst)
        !advance_ready_i |-> md_op)
        else begin
            $error("advance_ready_o low without a multiply or divide");
            fail_count++;
        end

    mul_latency: assert property (@(posedge clk) disable iff (rst)
        mul_start_i |-> ##2 mul_done_i)
        else begin
            $error("multiplier done missing two cycles after start");
            fail_count++;
        end

    mul_no_spurious: assert property (@(posedge clk) disable iff (rst)
        mul_done_i |-> $past(mul_start_i, 2))
        else begin
            $error("multiplier done without a start two cycles earlier");
            fail_count++;
        end

endmodule

bind ex_stage ex_stage_assert assert0 (
    .clk(clk), .rst(rst), .flush_i(flush_i), .advance_i(advance_i),
    .in_valid_i(in_valid_i), .aluop_i(aluop_i), .advance_ready_i(advance_ready_o),
    .out_valid_i(out_valid_o), .redirect_i(redirect_o),
    .mul_start_i(mul_start), .mul_done_i(mul_done)
);

`default_nettype wire

// File: tests/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int HALF = 20;
    localparam int TIMEOUT = 100;

    logic clk, rst, in_valid, wreg, pred_taken, advance, flush;
    aluop_t aluop;
    word_t pc, op1, op2, imm;
    reg_addr_t waddr;
    logic advance_ready, out_valid, out_wreg, out_load, out_store, out_ale;
    logic fwd_valid, fwd_data_ready, redirect;
    reg_addr_t out_waddr, fwd_waddr;
    word_t out_wdata, out_mem_addr, fwd_wdata, redirect_target;
    mem_size_t out_mem_size;

    integer seed;
    int checks;
    int errors;
    int sel;
    int base_checks;
    int base_errors;

    // Expected values from the reference model
    word_t exp_wdata, exp_addr, exp_target;
    mem_size_t exp_size;
    logic chk_wdata, exp_load, exp_store, exp_ale, exp_taken, exp_redirect;

    ex_stage dut0 (
        .clk(clk), .rst(rst), .in_valid_i(in_valid), .aluop_i(aluop), .pc_i(pc),
        .op1_i(op1), .op2_i(op2), .imm_i(imm), .waddr_i(waddr), .wreg_i(wreg),
        .predicted_taken_i(pred_taken), .advance_i(advance), .flush_i(flush),
        .advance_ready_o(advance_ready), .out_valid_o(out_valid), .out_wreg_o(out_wreg),
        .out_waddr_o(out_waddr), .out_wdata_o(out_wdata), .out_mem_addr_o(out_mem_addr),
        .out_mem_size_o(out_mem_size), .out_load_o(out_load), .out_store_o(out_store),
        .out_excp_ale_o(out_ale), .fwd_valid_o(fwd_valid),
        .fwd_data_ready_o(fwd_data_ready), .fwd_waddr_o(fwd_waddr),
        .fwd_wdata_o(fwd_wdata), .redirect_o(redirect), .redirect_target_o(redirect_target)
    );

    always #HALF clk = ~clk;

    function automatic logic is_md(input aluop_t op);
        return (op >= `EX_OP_MUL) && (op <= `EX_OP_MODU);
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    ////////////////////
    // Reference model
    task automatic ref_model();
        word_t dvs;
        logic [63:0] prod_u;
        longint prod_s;
        longint q;
        longint r;
        dvs    = (op2 == '0) ? word_t'(1) : op2;
        prod_u = {32'd0, op1} * {32'd0, op2};
        prod_s = longint'($signed(op1)) * longint'($signed(op2));
        // 64-bit math keeps most-negative by -1 exact
        q = longint'($signed(op1)) / longint'($signed(dvs));
        r = longint'($signed(op1)) % longint'($signed(dvs));
        chk_wdata = 1'b1;
        exp_wdata = '0;
        exp_taken = 1'b0;
        case (aluop)
            `EX_OP_ADD:   exp_wdata = op1 + op2;
            `EX_OP_SUB:   exp_wdata = op1 - op2;
            `EX_OP_AND:   exp_wdata = op1 & op2;
            `EX_OP_OR:    exp_wdata = op1 | op2;
            `EX_OP_XOR:   exp_wdata = op1 ^ op2;
            `EX_OP_NOR:   exp_wdata = ~(op1 | op2);
            `EX_OP_SLL:   exp_wdata = op1 << op2[4:0];
            `EX_OP_SRL:   exp_wdata = op1 >> op2[4:0];
            `EX_OP_SRA:   exp_wdata = $signed(op1) >>> op2[4:0];
            `EX_OP_SLT:   exp_wdata = word_t'($signed(op1) < $signed(op2));
            `EX_OP_SLTU:  exp_wdata = word_t'(op1 < op2);
            `EX_OP_LUI:   exp_wdata = op2;
            `EX_OP_PCADD: exp_wdata = pc + op2;
            `EX_OP_MUL:   exp_wdata = prod_u[31:0];
            `EX_OP_MULH:  exp_wdata = prod_s[63:32];
            `EX_OP_MULHU: exp_wdata = prod_u[63:32];
            `EX_OP_DIV:   exp_wdata = q[31:0];
            `EX_OP_DIVU:  exp_wdata = op1 / dvs;
            `EX_OP_MOD:   exp_wdata = r[31:0];
            `EX_OP_MODU:  exp_wdata = op1 % dvs;
            `EX_OP_JIRL: begin
                exp_wdata = pc + 32'd4;
                exp_taken = 1'b1;
            end
            default:      chk_wdata = 1'b0;
        endcase
        case (aluop)
            `EX_OP_BEQ:  exp_taken = (op1 == op2);
            `EX_OP_BNE:  exp_taken = (op1 != op2);
            `EX_OP_BLT:  exp_taken = ($signed(op1) < $signed(op2));
            `EX_OP_BGE:  exp_taken = ($signed(op1) >= $signed(op2));
            `EX_OP_BLTU: exp_taken = (op1 < op2);
            `EX_OP_BGEU: exp_taken = (op1 >= op2);
            default: ;
        endcase
        exp_redirect = exp_taken && (!pred_taken || aluop == `EX_OP_JIRL);
        exp_target   = (aluop == `EX_OP_JIRL) ? op1 + imm : pc + imm;
        exp_addr     = op1 + imm;
        exp_load     = (aluop >= `EX_OP_LDW) && (aluop <= `EX_OP_LDB);
        exp_store    = (aluop >= `EX_OP_STW) && (aluop <= `EX_OP_STB);
        exp_size     = (aluop == `EX_OP_LDB || aluop == `EX_OP_STB) ? 2'd0 :
                       (aluop == `EX_OP_LDH || aluop == `EX_OP_STH) ? 2'd1 : 2'd2;
        exp_ale      = (exp_load || exp_store) &&
                       ((exp_size == 2'd1 && exp_addr[0]) ||
                        (exp_size == 2'd2 && exp_addr[1:0] != 2'b00));
    endtask

    ////////////////////
    // Issue one instruction, called on a falling edge
    task automatic run_op(input aluop_t op, input word_t a, input word_t b, input word_t i,
                          input logic pt, input int hold);
        int cnt;
        word_t held;
        aluop      = op;
        op1        = a;
        op2        = b;
        imm        = i;
        pred_taken = pt;
        pc         = word_t'($random(seed)) & 32'hffff_fffc;
        waddr      = reg_addr_t'($random(seed));
        wreg       = 1'($random(seed));
        in_valid   = 1'b1;
        advance    = (hold == 0);
        ref_model();
        cnt = 0;
        #(HALF / 2);
        while (!advance_ready) begin
            check_value("fwd_data_ready_o", 0, fwd_data_ready);
            if (cnt == TIMEOUT) begin
                $display("Timeout at %0t: stage never became ready for op %0d", $time, op);
                $display("Simulation finished: FAIL");
                $finish;
            end
            cnt++;
            @(negedge clk);
            #(HALF / 2);
        end
        if (is_md(op)) begin
            check_true(cnt > 0, "advance_ready_o did not fall for a multi-cycle op");
        end
        if (hold > 0) begin
            held = fwd_wdata;
            repeat (hold) begin
                @(negedge clk);
                #(HALF / 2);
                check_value("advance_ready_o", 1, advance_ready);
                check_value("fwd_wdata_o", held, fwd_wdata);
            end
            @(negedge clk);
            advance = 1'b1;
            #(HALF / 2);
        end
        check_value("fwd_valid_o", wreg, fwd_valid);
        check_value("fwd_waddr_o", word_t'(waddr), word_t'(fwd_waddr));
        check_value("fwd_data_ready_o", !exp_load, fwd_data_ready);
        if (chk_wdata) check_value("fwd_wdata_o", exp_wdata, fwd_wdata);
        check_value("redirect_o", exp_redirect, redirect);
        if (exp_redirect) check_value("redirect_target_o", exp_target, redirect_target);
        @(posedge clk);
        @(negedge clk);
        check_value("out_valid_o", 1, out_valid);
        check_value("out_wreg_o", wreg, out_wreg);
        check_value("out_waddr_o", word_t'(waddr), word_t'(out_waddr));
        if (chk_wdata) check_value("out_wdata_o", exp_wdata, out_wdata);
        check_value("out_load_o", exp_load, out_load);
        check_value("out_store_o", exp_store, out_store);
        check_value("out_excp_ale_o", exp_ale, out_ale);
        if (exp_load || exp_store) begin
            check_value("out_mem_addr_o", exp_addr, out_mem_addr);
            check_value("out_mem_size_o", word_t'(exp_size), word_t'(out_mem_size));
        end
        in_valid = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %0d checks, %0d errors", num, name,
                 checks - base_checks, errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    initial begin
        seed = 32'h36c92180;
        checks = 0;
        errors = 0;
        base_checks = 0;
        base_errors = 0;
        clk = 1'b0;
        rst = 1'b1;
        {in_valid, wreg, pred_taken, advance, flush} = '0;
        aluop = '0;
        {pc, op1, op2, imm} = '0;
        waddr = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        repeat (40) begin
            sel = {$random(seed)} % 14;
            run_op((sel == 13) ? aluop_t'(`EX_OP_JIRL) : aluop_t'(sel),
                   $random(seed), $random(seed), $random(seed), 1'b0, 0);
        end
        end_test(1, "single-cycle ALU");

        for (int k = `EX_OP_MUL; k <= `EX_OP_MODU; k++) begin
            run_op(aluop_t'(k), $random(seed), $random(seed), '0, 1'b0, 0);
            run_op(aluop_t'(k), $random(seed), $random(seed), '0, 1'b0, 3);
        end
        // Corner cases of the divider
        run_op(`EX_OP_DIV, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0, 0);
        run_op(`EX_OP_MOD, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0, 0);
        run_op(`EX_OP_DIV, 32'hffff_ff85, '0, '0, 1'b0, 2);
        run_op(`EX_OP_DIVU, 32'h1234_5678, '0, '0, 1'b0, 0);
        run_op(`EX_OP_MOD, 32'hffff_ff85, '0, '0, 1'b0, 0);
        run_op(`EX_OP_MODU, 32'h8765_4321, '0, '0, 1'b0, 2);
        end_test(2, "multiply and divide");

        for (int k = `EX_OP_LDW; k <= `EX_OP_STB; k++) begin
            repeat (4) run_op(aluop_t'(k), $random(seed), $random(seed), $random(seed), 1'b0, 0);
        end
        end_test(3, "load and store");

        for (int k = `EX_OP_BEQ; k <= `EX_OP_JIRL; k++) begin
            repeat (6) begin
                op1 = $random(seed);
                op2 = ($random(seed) & 1) ? op1 : word_t'($random(seed));
                run_op(aluop_t'(k), op1, op2, $random(seed), $random(seed), 0);
            end
        end
        end_test(4, "branch and jump");

        run_op(`EX_OP_ADD, $random(seed), $random(seed), '0, 1'b0, 0);
        aluop    = `EX_OP_DIV;
        op1      = $random(seed);
        op2      = $random(seed);
        in_valid = 1'b1;
        advance  = 1'b1;
        repeat (5) @(negedge clk);
        check_value("advance_ready_o", 0, advance_ready);
        flush    = 1'b1;
        in_valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        check_value("out_valid_o", 0, out_valid);
        run_op(`EX_OP_ADD, $random(seed), $random(seed), '0, 1'b0, 0);
        run_op(`EX_OP_DIV, $random(seed), $random(seed), '0, 1'b0, 0);
        end_test(5, "flush during divide");

        errors += dut0.assert0.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mul_unit.sv
verilog/ex_div_unit.sv
verilog/ex_mem_addr.sv
verilog/ex_ctrl.sv
verilog/ex_stage.sv
tests/ex_stage_assert.sv
tests/ex_stage_tb.sv
